// ==== hdl/cachePkg.sv ====
`default_nettype none

package cachePkg;

  //////////////////////////////
  // Address and line geometry
  //////////////////////////////

  // Physical byte address width
  localparam int PaBits    = 16;
  // CPU and bus data word
  localparam int WordLen   = 32;
  localparam int LineWords = 4;
  // Byte offset inside one line
  localparam int OffsetLen = 4;
  localparam int LineLen   = WordLen * LineWords;
  localparam int LineBytes = LineLen / 8;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // CPU request opcode
  typedef enum logic [1:0] {
    opNone  = 2'd0,
    opRead  = 2'd1,
    opWrite = 2'd2,
    opFlush = 2'd3
  } cacheOpE;

  // Line transfer command to the bus master
  typedef enum logic [1:0] {
    busIdle      = 2'd0,
    busWriteBack = 2'd1,
    busFetch     = 2'd2
  } busOpE;

  // Cache controller states
  typedef enum logic [2:0] {
    stReady          = 3'd0,
    stWriteBack      = 3'd1,
    stFetch          = 3'd2,
    stFlushCheck     = 3'd3,
    stFlushWriteBack = 3'd4,
    stFlushDone      = 3'd5
  } cacheStateE;

  //////////////////////////////
  // Bundles
  //////////////////////////////

  // CPU request, held until stall is sampled low
  typedef struct packed {
    cacheOpE             op;
    logic [PaBits-1:0]   adr;
    logic [3:0]          byteMask;
    logic [WordLen-1:0]  writeData;
  } cpuReqT;

  // Wishbone master side
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [PaBits-1:0]   adr;
    logic [3:0]          sel;
    logic [WordLen-1:0]  dat;
  } wbMasterT;

  // Wishbone slave side
  typedef struct packed {
    logic                ack;
    logic [WordLen-1:0]  dat;
  } wbSlaveT;

endpackage

`default_nettype wire

// ==== hdl/cacheWay.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheWay #(
  parameter int NumSets = 16,
  localparam int SetLen = $clog2(NumSets),
  localparam int TagLen = cachePkg::PaBits - SetLen - cachePkg::OffsetLen
) (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic [SetLen-1:0]             setIdx,
  input  logic [TagLen-1:0]             tag,
  input  logic [cachePkg::LineLen-1:0]  writeLine,
  input  logic [cachePkg::LineBytes-1:0] lineByteMask,
  input  logic                          wayWrite,
  input  logic                          setValid,
  input  logic                          setDirty,
  input  logic                          clearDirty,
  input  logic                          selWay,
  output logic                          hit,
  output logic [cachePkg::LineLen-1:0]  lineOut,
  output logic                          victimDirty,
  output logic [TagLen-1:0]             victimTag
);

  // Per-set storage
  logic [TagLen-1:0]             tagArray  [NumSets];
  logic [cachePkg::LineLen-1:0]  lineArray [NumSets];
  logic [NumSets-1:0]            validBits;
  logic [NumSets-1:0]            dirtyBits;

  //////////////////////////////
  // Lookup
  //////////////////////////////

  // Tag compare against the addressed set
  assign hit = validBits[setIdx] && (tagArray[setIdx] == tag);

  // AND half of the AND-OR read mux
  // selWay already carries the hit or victim choice from the top
  assign lineOut = lineArray[setIdx] & {cachePkg::LineLen{selWay}};

  // Victim info only from the selected way, so the top can OR it
  assign victimDirty = selWay && validBits[setIdx] && dirtyBits[setIdx];
  assign victimTag   = tagArray[setIdx] & {TagLen{selWay}};

  //////////////////////////////
  // Status bits
  //////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (setValid) begin
      // Line install, dirty only for a write miss
      validBits[setIdx] <= 1'b1;
      dirtyBits[setIdx] <= setDirty;
    end else if (setDirty) begin
      dirtyBits[setIdx] <= 1'b1;
    end else if (clearDirty) begin
      // Line written back during flush
      dirtyBits[setIdx] <= 1'b0;
    end
  end

  //////////////////////////////
  // Tag and data arrays
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (setValid) begin
      tagArray[setIdx] <= tag;
    end
    // Byte-enabled line write
    if (wayWrite) begin
      for (int b = 0; b < cachePkg::LineBytes; b++) begin
        if (lineByteMask[b]) begin
          lineArray[setIdx][8*b +: 8] <= writeLine[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cacheFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheFsm #(
  parameter int NumSets = 16,
  localparam int SetLen = $clog2(NumSets)
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  cachePkg::cacheOpE    op,
  input  logic                 cacheHit,
  input  logic                 victimDirty,
  input  logic                 busDone,
  output logic                 stall,
  output logic                 cacheMiss,
  output logic                 cacheAccess,
  output cachePkg::busOpE      busCmd,
  output logic                 selEvict,
  output logic                 selFlush,
  output logic                 setValid,
  output logic                 setDirty,
  output logic                 clearDirty,
  output logic                 lruWrite,
  output logic [SetLen-1:0]    flushSet,
  output logic                 flushWay
);

  cachePkg::cacheStateE state;
  cachePkg::cacheStateE nextState;
  // High for the retry cycle right after a line install
  logic refill;
  logic isRw;
  logic isWrite;
  logic lastEntry;
  logic flushAdvance;

  assign isWrite = (op == cachePkg::opWrite);
  assign isRw    = (op == cachePkg::opRead) || isWrite;

  // Flush walk ends on way 1 of the last set
  assign lastEntry    = flushWay && (flushSet == SetLen'(NumSets - 1));
  assign flushAdvance = (state == cachePkg::stFlushCheck) && !victimDirty && !lastEntry;

  // Performance pulses only on the first cycle of a request
  assign cacheAccess = (state == cachePkg::stReady) && isRw && !refill;
  assign cacheMiss   = cacheAccess && !cacheHit;

  //////////////////////////////
  // Next state and controls
  //////////////////////////////

  always_comb begin
    nextState  = state;
    stall      = 1'b1;
    busCmd     = cachePkg::busIdle;
    selEvict   = 1'b0;
    selFlush   = 1'b0;
    setValid   = 1'b0;
    setDirty   = 1'b0;
    clearDirty = 1'b0;
    lruWrite   = 1'b0;
    case (state)
      cachePkg::stReady: begin
        stall = 1'b0;
        if (isRw) begin
          if (cacheHit) begin
            // Hit completes now
            setDirty = isWrite;
            lruWrite = 1'b1;
          end else begin
            stall     = 1'b1;
            nextState = victimDirty ? cachePkg::stWriteBack : cachePkg::stFetch;
          end
        end else if (op == cachePkg::opFlush) begin
          stall     = 1'b1;
          nextState = cachePkg::stFlushCheck;
        end
      end
      cachePkg::stWriteBack: begin
        // Victim tag drives the bus address
        busCmd   = cachePkg::busWriteBack;
        selEvict = 1'b1;
        if (busDone) begin
          nextState = cachePkg::stFetch;
        end
      end
      cachePkg::stFetch: begin
        busCmd = cachePkg::busFetch;
        if (busDone) begin
          // Install cycle with the write bytes merged in by the top
          setValid  = 1'b1;
          setDirty  = isWrite;
          nextState = cachePkg::stReady;
        end
      end
      cachePkg::stFlushCheck: begin
        selFlush = 1'b1;
        if (victimDirty) begin
          nextState = cachePkg::stFlushWriteBack;
        end else if (lastEntry) begin
          nextState = cachePkg::stFlushDone;
        end
      end
      cachePkg::stFlushWriteBack: begin
        selFlush = 1'b1;
        busCmd   = cachePkg::busWriteBack;
        if (busDone) begin
          // Same entry is checked again and is now clean
          clearDirty = 1'b1;
          nextState  = cachePkg::stFlushCheck;
        end
      end
      cachePkg::stFlushDone: begin
        stall     = 1'b0;
        nextState = cachePkg::stReady;
      end
      default: begin
        nextState = cachePkg::stReady;
      end
    endcase
  end

  //////////////////////////////
  // State and flush counters
  //////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= cachePkg::stReady;
      refill   <= 1'b0;
      flushSet <= '0;
      flushWay <= 1'b0;
    end else begin
      state  <= nextState;
      refill <= (state == cachePkg::stFetch) && busDone;
      if (state == cachePkg::stReady) begin
        // Every flush starts at set 0 and way 0
        flushSet <= '0;
        flushWay <= 1'b0;
      end else if (flushAdvance) begin
        flushWay <= !flushWay;
        if (flushWay) begin
          flushSet <= flushSet + 1'b1;
        end
      end
    end
  end

  // Installed line must hit on the retry cycle and release the CPU
  stallRetryA: assert property (@(posedge clk) disable iff (!arstN)
    (state == cachePkg::stFetch) && busDone |=> !stall);

endmodule

`default_nettype wire

// ==== hdl/wbLineMaster.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbLineMaster (
  input  logic                                         clk,
  input  logic                                         arstN,
  input  cachePkg::busOpE                              busCmd,
  input  logic [cachePkg::PaBits-cachePkg::OffsetLen-1:0] busAdr,
  input  logic [cachePkg::LineLen-1:0]                 evictLine,
  input  cachePkg::wbSlaveT                            wbIn,
  output cachePkg::wbMasterT                           wbOut,
  output logic [cachePkg::LineLen-1:0]                 fetchLine,
  output logic                                         busDone
);

  localparam int CntLen  = $clog2(cachePkg::LineWords);
  localparam int ByteLen = cachePkg::OffsetLen - CntLen;

  logic              cycReg;
  logic [CntLen-1:0] wordCnt;
  logic              wordAck;
  logic              lastAck;

  assign wordAck = cycReg && wbIn.ack;
  assign lastAck = wordAck && (wordCnt == CntLen'(cachePkg::LineWords - 1));

  //////////////////////////////
  // Word sequencing
  //////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cycReg  <= 1'b0;
      wordCnt <= '0;
      busDone <= 1'b0;
    end else begin
      busDone <= lastAck;
      if (cycReg) begin
        // One classic cycle per word, dropped at ack
        if (wbIn.ack) begin
          cycReg  <= 1'b0;
          wordCnt <= wordCnt + 1'b1;
        end
      end else if (busCmd != cachePkg::busIdle && !busDone) begin
        // No restart while the FSM still sees busDone
        cycReg <= 1'b1;
      end
    end
  end

  // Fetch buffer, one word per ack
  always_ff @(posedge clk) begin
    if (wordAck && busCmd == cachePkg::busFetch) begin
      fetchLine[wordCnt*cachePkg::WordLen +: cachePkg::WordLen] <= wbIn.dat;
    end
  end

  //////////////////////////////
  // Bus outputs
  //////////////////////////////

  always_comb begin
    wbOut.cyc = cycReg;
    wbOut.stb = cycReg;
    wbOut.we  = (busCmd == cachePkg::busWriteBack);
    // Byte address of the current word
    wbOut.adr = {busAdr, wordCnt, {ByteLen{1'b0}}};
    wbOut.sel = '1;
    wbOut.dat = evictLine[wordCnt*cachePkg::WordLen +: cachePkg::WordLen];
  end

  // Strobe only inside a cycle, held with its address until ack
  wbHoldA: assert property (@(posedge clk) disable iff (!arstN)
    (wbOut.stb |-> wbOut.cyc) and
    (wbOut.stb && !wbIn.ack |=> wbOut.stb && $stable(wbOut.adr) && $stable(wbOut.we)));

endmodule

`default_nettype wire

// ==== hdl/dataCache.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataCache #(
  parameter int NumSets = 16
) (
  input  logic                         clk,
  input  logic                         arstN,
  input  cachePkg::cpuReqT             req,
  input  cachePkg::wbSlaveT            wbIn,
  output logic                         stall,
  output logic [cachePkg::WordLen-1:0] readData,
  output logic                         cacheMiss,
  output logic                         cacheAccess,
  output cachePkg::wbMasterT           wbOut
);

  localparam int SetLen   = $clog2(NumSets);
  localparam int TagLen   = cachePkg::PaBits - SetLen - cachePkg::OffsetLen;
  localparam int LineLen  = cachePkg::LineLen;
  localparam int WordLen  = cachePkg::WordLen;
  localparam int ByteLen  = $clog2(WordLen / 8);
  localparam int LineAdrLen = cachePkg::PaBits - cachePkg::OffsetLen;

  // Request address fields
  logic [TagLen-1:0]              reqTag;
  logic [SetLen-1:0]              reqSet;
  logic [cachePkg::OffsetLen-ByteLen-1:0] wordIdx;
  logic [SetLen-1:0]              setIdx;

  // Way results and controls
  logic [1:0]                     hitWay;
  logic [1:0]                     selWay;
  logic [1:0]                     wayWrite;
  logic [1:0]                     setValidWay;
  logic [1:0]                     setDirtyWay;
  logic [1:0]                     clearDirtyWay;
  logic [1:0]                     victimDirtyWay;
  logic [LineLen-1:0]             lineWay0;
  logic [LineLen-1:0]             lineWay1;
  logic [TagLen-1:0]              victimTag0;
  logic [TagLen-1:0]              victimTag1;
  logic [LineLen-1:0]             mergedLine;
  logic [TagLen-1:0]              victimTag;
  logic                           cacheHit;
  logic                           victimDirty;

  // FSM controls
  cachePkg::busOpE                busCmd;
  logic                           selEvict;
  logic                           selFlush;
  logic                           setValid;
  logic                           setDirty;
  logic                           clearDirty;
  logic                           lruWrite;
  logic [SetLen-1:0]              flushSet;
  logic                           flushWay;
  logic                           busDone;

  // Write path
  logic [NumSets-1:0]             lruBits;
  logic                           victimWay;
  logic [cachePkg::LineBytes-1:0] demuxMask;
  logic [cachePkg::LineBytes-1:0] lineByteMask;
  logic [LineLen-1:0]             writeLine;
  logic [LineLen-1:0]             fetchLine;
  logic [LineAdrLen-1:0]          busAdr;

  assign reqTag  = req.adr[cachePkg::PaBits-1 -: TagLen];
  assign reqSet  = req.adr[cachePkg::OffsetLen +: SetLen];
  assign wordIdx = req.adr[cachePkg::OffsetLen-1:ByteLen];

  //////////////////////////////
  // Read path
  //////////////////////////////

  // Flush walk overrides the request set
  assign setIdx = selFlush ? flushSet : reqSet;

  // Selected way: flush way, else hit way, else LRU victim
  assign victimWay = lruBits[setIdx];
  always_comb begin
    if (selFlush) begin
      selWay = {flushWay, !flushWay};
    end else if (cacheHit) begin
      selWay = hitWay;
    end else begin
      selWay = {victimWay, !victimWay};
    end
  end

  cacheWay #(.NumSets(NumSets)) way0 (
    .clk, .arstN, .setIdx, .tag(reqTag), .writeLine, .lineByteMask,
    .wayWrite(wayWrite[0]), .setValid(setValidWay[0]), .setDirty(setDirtyWay[0]),
    .clearDirty(clearDirtyWay[0]), .selWay(selWay[0]), .hit(hitWay[0]),
    .lineOut(lineWay0), .victimDirty(victimDirtyWay[0]), .victimTag(victimTag0));

  cacheWay #(.NumSets(NumSets)) way1 (
    .clk, .arstN, .setIdx, .tag(reqTag), .writeLine, .lineByteMask,
    .wayWrite(wayWrite[1]), .setValid(setValidWay[1]), .setDirty(setDirtyWay[1]),
    .clearDirty(clearDirtyWay[1]), .selWay(selWay[1]), .hit(hitWay[1]),
    .lineOut(lineWay1), .victimDirty(victimDirtyWay[1]), .victimTag(victimTag1));

  // OR half of the AND-OR muxes
  assign cacheHit    = |hitWay;
  assign victimDirty = |victimDirtyWay;
  assign mergedLine  = lineWay0 | lineWay1;
  assign victimTag   = victimTag0 | victimTag1;
  assign readData    = mergedLine[wordIdx*WordLen +: WordLen];

  //////////////////////////////
  // Write path
  //////////////////////////////

  // Byte mask placed on the addressed word
  always_comb begin
    demuxMask = '0;
    demuxMask[wordIdx*(WordLen/8) +: (WordLen/8)] = req.byteMask;
  end

  // CPU bytes over the fetched line, full line on install
  always_comb begin
    for (int b = 0; b < cachePkg::LineBytes; b++) begin
      if (demuxMask[b] && req.op == cachePkg::opWrite) begin
        writeLine[8*b +: 8] = req.writeData[8*(b % (WordLen/8)) +: 8];
      end else begin
        writeLine[8*b +: 8] = fetchLine[8*b +: 8];
      end
    end
  end
  assign lineByteMask = setValid ? '1 : demuxMask;

  // Enables gated to the selected way
  assign wayWrite      = (setValid || setDirty) ? selWay : 2'b00;
  assign setValidWay   = setValid ? selWay : 2'b00;
  assign setDirtyWay   = setDirty ? selWay : 2'b00;
  assign clearDirtyWay = clearDirty ? selWay : 2'b00;

  // LRU bit names the next victim, the way not just used
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      lruBits <= '0;
    end else if (lruWrite) begin
      lruBits[setIdx] <= hitWay[0];
    end
  end

  //////////////////////////////
  // Bus side
  //////////////////////////////

  // Line address for fetch, eviction or flush
  always_comb begin
    if (selFlush) begin
      busAdr = {victimTag, flushSet};
    end else if (selEvict) begin
      busAdr = {victimTag, reqSet};
    end else begin
      busAdr = req.adr[cachePkg::PaBits-1:cachePkg::OffsetLen];
    end
  end

  cacheFsm #(.NumSets(NumSets)) fsm0 (
    .clk, .arstN, .op(req.op), .cacheHit, .victimDirty, .busDone,
    .stall, .cacheMiss, .cacheAccess, .busCmd, .selEvict, .selFlush,
    .setValid, .setDirty, .clearDirty, .lruWrite, .flushSet, .flushWay);

  // Victim or flush line is the write-back source
  wbLineMaster bus0 (
    .clk, .arstN, .busCmd, .busAdr, .evictLine(mergedLine), .wbIn,
    .wbOut, .fetchLine, .busDone);

  // A line lives in at most one way
  hitOneHotA: assert property (@(posedge clk) disable iff (!arstN)
    !(hitWay[0] && hitWay[1]));

endmodule

`default_nettype wire

// ==== tests/wbMemModel.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbMemModel #(
  parameter int Words   = 16384,
  parameter int Seed    = 32'hb442,
  parameter int MaxWait = 7
) (
  input  logic               clk,
  input  logic               arstN,
  input  cachePkg::wbMasterT bus,
  output cachePkg::wbSlaveT  resp
);

  // Word-organized backing store
  logic [cachePkg::WordLen-1:0] memWords [Words];
  integer                       seed = Seed;
  logic                         busy;
  int                           waitLeft;
  logic [cachePkg::PaBits-3:0]  wordIdx;

  assign wordIdx = bus.adr[cachePkg::PaBits-1:2];

  //////////////////////////////
  // Classic slave with random wait states
  //////////////////////////////

  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resp.ack <= 1'b0;
      resp.dat <= '0;
      busy     <= 1'b0;
      waitLeft <= 0;
    end else if (resp.ack) begin
      // Single-cycle ack, master drops cyc at this edge
      resp.ack <= 1'b0;
    end else if (bus.cyc && bus.stb) begin
      if (!busy) begin
        busy     <= 1'b1;
        waitLeft <= $unsigned($random(seed)) % (MaxWait + 1);
      end else if (waitLeft != 0) begin
        waitLeft <= waitLeft - 1;
      end else begin
        busy     <= 1'b0;
        resp.ack <= 1'b1;
        if (bus.we) begin
          for (int b = 0; b < 4; b++) begin
            if (bus.sel[b]) begin
              memWords[wordIdx][8*b +: 8] = bus.dat[8*b +: 8];
            end
          end
        end else begin
          resp.dat <= memWords[wordIdx];
        end
      end
    end
  end

  // Backdoor access for setup and checks
  task automatic pokeWord(input int idx, input logic [cachePkg::WordLen-1:0] w);
    memWords[idx] = w;
  endtask

  function automatic logic [cachePkg::WordLen-1:0] peekWord(input int idx);
    return memWords[idx];
  endfunction

endmodule

`default_nettype wire

// ==== tests/tbDataCache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbDataCache;

  localparam int NumSets     = 16;
  localparam int SetBits     = $clog2(NumSets);
  localparam int TagBits     = cachePkg::PaBits - SetBits - cachePkg::OffsetLen;
  localparam int LineAdrBits = cachePkg::PaBits - cachePkg::OffsetLen;
  localparam int MemWords    = 2 ** (cachePkg::PaBits - 2);
  // About 40 requests, 8 transfers each, up to 12 cycles per transfer
  localparam int MaxCycles   = 40 * 8 * 12 + 160;
  localparam int RandomReqs  = 20;

  logic                         clk;
  logic                         arstN;
  cachePkg::cpuReqT             req;
  cachePkg::wbSlaveT            wbIn;
  cachePkg::wbMasterT           wbOut;
  logic                         stall;
  logic [cachePkg::WordLen-1:0] readData;
  logic                         cacheMiss;
  logic                         cacheAccess;

  integer seed = 32'hb442;
  int     cycleCount = 0;
  int     ackCount = 0;

  // Shadow memory: CPU view and expected backing store
  logic [31:0]            cpuView  [MemWords];
  logic [31:0]            memImage [MemWords];
  // Shadow cache image
  logic [TagBits-1:0]     modelTag   [NumSets][2];
  logic                   modelValid [NumSets][2];
  logic                   modelDirty [NumSets][2];
  logic                   modelLru   [NumSets];
  logic [LineAdrBits-1:0] touched [$];

  dataCache #(.NumSets(NumSets)) dut0 (
    .clk, .arstN, .req, .wbIn, .stall, .readData, .cacheMiss, .cacheAccess, .wbOut);

  wbMemModel #(.Words(MemWords), .Seed(32'hb442)) mem0 (
    .clk, .arstN, .bus(wbOut), .resp(wbIn));

  always #50 clk = ~clk;

  //////////////////////////////
  // Monitors
  //////////////////////////////

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= MaxCycles) begin
      failRun($sformatf("Timeout, run did not finish within %0d cycles", MaxCycles));
    end
  end

  // Completed bus words
  always @(posedge clk) begin
    if (wbOut.cyc && wbIn.ack) begin
      ackCount <= ackCount + 1;
    end
  end

  // No bus traffic while the CPU is let through
  always @(negedge clk) begin
    if (arstN && !stall && wbOut.cyc) begin
      failRun("Bus cycle active while stall is low");
    end
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      failRun($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      failRun($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkLine(input string name, input logic [cachePkg::LineLen-1:0] got,
                           input logic [cachePkg::LineLen-1:0] exp);
    if (got !== exp) begin
      failRun($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Initial memory word, built from the whole word address
  function automatic logic [31:0] patternWord(input logic [13:0] idx);
    return {2'b10, idx, ~idx, 2'b01};
  endfunction

  //////////////////////////////
  // Shadow cache model
  //////////////////////////////

  // Write-back of one line into the expected memory
  task automatic copyLine(input logic [LineAdrBits-1:0] lineAdr);
    for (int w = 0; w < 4; w++) begin
      memImage[{lineAdr, 2'(w)}] = cpuView[{lineAdr, 2'(w)}];
    end
  endtask

  task automatic modelAccess(input cachePkg::cpuReqT r, output logic hit,
                             output int transfers, output logic [31:0] word);
    logic [SetBits-1:0] set;
    logic [TagBits-1:0] tag;
    logic [13:0]        idx;
    int                 way;
    set = r.adr[cachePkg::OffsetLen +: SetBits];
    tag = r.adr[cachePkg::PaBits-1 -: TagBits];
    idx = r.adr[cachePkg::PaBits-1:2];
    hit = 1'b0;
    way = 0;
    transfers = 0;
    for (int w = 0; w < 2; w++) begin
      if (modelValid[set][w] && modelTag[set][w] == tag) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      // LRU bit names the victim, dirty victim goes out first
      way = modelLru[set];
      transfers = 4;
      if (modelValid[set][way] && modelDirty[set][way]) begin
        copyLine({modelTag[set][way], set});
        transfers = 8;
      end
      modelValid[set][way] = 1'b1;
      modelTag[set][way]   = tag;
      modelDirty[set][way] = 1'b0;
      touched.push_back(r.adr[cachePkg::PaBits-1:cachePkg::OffsetLen]);
    end
    if (r.op == cachePkg::opWrite) begin
      for (int b = 0; b < 4; b++) begin
        if (r.byteMask[b]) begin
          cpuView[idx][8*b +: 8] = r.writeData[8*b +: 8];
        end
      end
      modelDirty[set][way] = 1'b1;
    end
    modelLru[set] = (way == 0);
    word = cpuView[idx];
  endtask

  // Flush keeps valid lines, cleans the dirty ones
  task automatic modelFlush(output int transfers);
    transfers = 0;
    for (int s = 0; s < NumSets; s++) begin
      for (int w = 0; w < 2; w++) begin
        if (modelValid[s][w] && modelDirty[s][w]) begin
          copyLine({modelTag[s][w], SetBits'(s)});
          modelDirty[s][w] = 1'b0;
          transfers += 4;
        end
      end
    end
  endtask

  //////////////////////////////
  // Request driver and memory compare
  //////////////////////////////

  // Called 1 ns after a rising edge, returns at the same point
  task automatic issueRequest(input cachePkg::cacheOpE op, input logic [15:0] adr,
                              input logic [3:0] mask, input logic [31:0] data);
    cachePkg::cpuReqT r;
    logic             expHit;
    int               expTransfers;
    logic [31:0]      expWord;
    int               acksBefore;
    logic             gotAccess;
    logic             gotMiss;
    logic [31:0]      gotWord;
    r.op = op;
    r.adr = adr;
    r.byteMask = mask;
    r.writeData = data;
    expHit = 1'b1;
    expWord = '0;
    if (op == cachePkg::opFlush) begin
      modelFlush(expTransfers);
    end else begin
      modelAccess(r, expHit, expTransfers, expWord);
    end
    acksBefore = ackCount;
    req = r;
    // Pulses only in the first cycle
    @(negedge clk);
    gotAccess = cacheAccess;
    gotMiss = cacheMiss;
    while (stall) begin
      @(negedge clk);
    end
    gotWord = readData;
    @(posedge clk);
    #1;
    req.op = cachePkg::opNone;
    checkFlag("cacheAccess", gotAccess, op != cachePkg::opFlush);
    checkFlag("cacheMiss", gotMiss, !expHit);
    checkWord("busTransfers", 32'(ackCount - acksBefore), 32'(expTransfers));
    if (op == cachePkg::opRead) begin
      checkWord("readData", gotWord, expWord);
    end
  endtask

  task automatic compareMemLine(input logic [LineAdrBits-1:0] lineAdr);
    logic [cachePkg::LineLen-1:0] got;
    logic [cachePkg::LineLen-1:0] exp;
    for (int w = 0; w < 4; w++) begin
      got[32*w +: 32] = mem0.peekWord({lineAdr, 2'(w)});
      exp[32*w +: 32] = memImage[{lineAdr, 2'(w)}];
    end
    checkLine($sformatf("memLine[0x%h]", lineAdr), got, exp);
  endtask

  task automatic compareTouched();
    foreach (touched[i]) begin
      compareMemLine(touched[i]);
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  // Same line twice, miss then hit
  task automatic testMissThenHit();
    issueRequest(cachePkg::opRead, 16'h1234, 4'h0, 32'h0);
    issueRequest(cachePkg::opRead, 16'h1234, 4'h0, 32'h0);
  endtask

  // Partial write stays in the cache
  task automatic testPartialWrite();
    issueRequest(cachePkg::opWrite, 16'h1238, 4'b0101, 32'hdeadbeef);
    issueRequest(cachePkg::opRead, 16'h1238, 4'h0, 32'h0);
    compareMemLine(12'h123);
  endtask

  // Three tags in set 3, dirty LRU line is evicted
  task automatic testEviction();
    issueRequest(cachePkg::opWrite, 16'h4534, 4'hf, 32'h0badf00d);
    issueRequest(cachePkg::opRead, 16'h783c, 4'h0, 32'h0);
    compareMemLine(12'h123);
  endtask

  task automatic testFlush();
    issueRequest(cachePkg::opFlush, 16'h0000, 4'h0, 32'h0);
    compareTouched();
    // Valid kept, so no bus words
    issueRequest(cachePkg::opRead, 16'h4534, 4'h0, 32'h0);
  endtask

  task automatic testRandomTraffic();
    logic [7:0]        tagPick [4];
    cachePkg::cacheOpE op;
    logic [15:0]       adr;
    logic [3:0]        mask;
    logic [31:0]       data;
    tagPick = '{8'h12, 8'h45, 8'h78, 8'h9a};
    for (int i = 0; i < RandomReqs; i++) begin
      adr[15:8] = tagPick[$unsigned($random(seed)) % 4];
      adr[7:4]  = 4'($unsigned($random(seed)) % 4);
      adr[3:2]  = 2'($unsigned($random(seed)) % 4);
      adr[1:0]  = 2'b00;
      op = ($random(seed) & 1) ? cachePkg::opWrite : cachePkg::opRead;
      mask = 4'($random(seed));
      if (mask == 4'h0) begin
        mask = 4'hf;
      end
      data = $random(seed);
      issueRequest(op, adr, mask, data);
    end
    issueRequest(cachePkg::opFlush, 16'h0000, 4'h0, 32'h0);
    compareTouched();
  endtask

  initial begin
    clk = 1'b0;
    arstN = 1'b0;
    req = '0;
    for (int i = 0; i < MemWords; i++) begin
      cpuView[i] = patternWord(14'(i));
      memImage[i] = cpuView[i];
      mem0.pokeWord(i, cpuView[i]);
    end
    for (int s = 0; s < NumSets; s++) begin
      modelLru[s] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        modelValid[s][w] = 1'b0;
        modelDirty[s][w] = 1'b0;
        modelTag[s][w] = '0;
      end
    end
    repeat (2) @(posedge clk);
    #1;
    arstN = 1'b1;
    // Idle outputs after reset
    @(negedge clk);
    checkFlag("stall", stall, 1'b0);
    checkFlag("wbOut.cyc", wbOut.cyc, 1'b0);
    checkFlag("cacheMiss", cacheMiss, 1'b0);
    checkFlag("cacheAccess", cacheAccess, 1'b0);
    @(posedge clk);
    #1;
    testMissThenHit();
    testPartialWrite();
    testEviction();
    testFlush();
    testRandomTraffic();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/cachePkg.sv
hdl/cacheWay.sv
hdl/cacheFsm.sv
hdl/wbLineMaster.sv
hdl/dataCache.sv
tests/wbMemModel.sv
tests/tbDataCache.sv
